/* list.f */
hdl/icap_multiboot_pkg.sv
hdl/boot_address_map.sv
hdl/icap_sequencer.sv
hdl/switch_select.sv
hdl/icap_multiboot_top.sv
verif/icap_model.sv
verif/icap_multiboot_assert.sv
verif/tb_icap_multiboot.sv

/* Makefile */
TOP := tb_icap_multiboot

sim:
	verilator --binary --timing --assert -f list.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

.PHONY: sim clean

/* verif/tb_icap_multiboot.sv */
`timescale 1ns/1ps

module tb_icap_multiboot
   import icap_multiboot_pkg::*;
();

   localparam int STARTUP_CYCLES = 15;
   localparam int DRIVE_DELAY    = 2;

   logic        clk_16M00;
   logic        rst;
   design_num_t design_num;
   logic        reconfigure;
   logic        powerup;
   sw_t         sw_in;
   sw_t         sw_out;
   sw_t         pwr_out;
   logic        initialized;
   icap_cmd_t   icap_cmd;
   icap_rsp_t   icap_rsp;
   icap_word_t  gen5_value;
   logic [31:0] rng_state = 32'h363c_bba4;

   icap_multiboot_top #(
      .STARTUP_CYCLES (STARTUP_CYCLES)
   ) DUT (
      .clk_16M00   (clk_16M00),
      .rst         (rst),
      .design_num  (design_num),
      .reconfigure (reconfigure),
      .powerup     (powerup),
      .sw_in       (sw_in),
      .sw_out      (sw_out),
      .pwr_out     (pwr_out),
      .initialized (initialized),
      .icap_cmd    (icap_cmd),
      .icap_rsp    (icap_rsp)
   );

   icap_model model (
      .clk_16M00  (clk_16M00),
      .rst        (rst),
      .icap_cmd   (icap_cmd),
      .gen5_value (gen5_value),
      .icap_rsp   (icap_rsp)
   );

   initial clk_16M00 = 1'b0;
   always #10 clk_16M00 = ~clk_16M00;

   // ------------------------------------------------------------------------
   // Helpers
   // ------------------------------------------------------------------------
   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   function automatic logic [31:0] next_random();
      rng_state = xorshift32(rng_state);
      return rng_state;
   endfunction

   // Boot address table, {gen1, gen2}
   function automatic logic [31:0] boot_words(input design_num_t d);
      case (d) inside
         5'd0:          return {16'h4000, 16'h0305};
         5'd1:          return {16'h8000, 16'h030A};
         5'd2:          return {16'hC000, 16'h030F};
         5'd3:          return {16'h0000, 16'h0315};
         5'd4:          return {16'h4000, 16'h031A};
         5'd7:          return {16'h0000, 16'h032A};
         [5'd8:5'd11]:  return {16'h8000, 16'h031F};
         [5'd12:5'd15]: return {16'hC000, 16'h0324};
         5'd16:         return {16'h0000, 16'h0300};
         default:       return {16'h4000, 16'h032F};
      endcase
   endfunction

   task automatic fail_run();
      $display("=== FAIL ===");
      $fatal(1, "Run stopped at the first error");
   endtask

   task automatic next_cycle();
      @(posedge clk_16M00);
      #DRIVE_DELAY;
   endtask

   task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                              input string what);
      assert (got === exp)
      else
      begin
         $display("MISMATCH at %0t ns: %s got %0h expected %0h", $time, what, got, exp);
         fail_run();
      end
   endtask

   task automatic wait_init(input logic level, input int limit, input string what);
      int n;
      n = 0;
      while (initialized !== level && n < limit)
      begin
         next_cycle();
         n++;
      end
      assert (initialized === level)
      else
      begin
         $display("Timeout after %0d cycles: %s", limit, what);
         fail_run();
      end
   endtask

   task automatic apply_reset();
      rst = 1'b1;
      next_cycle();
      next_cycle();
      check_value(32'(initialized), 32'd0, "initialized in reset");
      check_value(32'(icap_cmd.csib), 32'd1, "csib in reset");
      rst = 1'b0;
   endtask

   task automatic check_readback_stream();
      icap_word_t want [4] = '{16'hAA99, 16'h5566, 16'h2AE1, 16'h30A1};
      int         k;
      int         n;
      k = 0;
      n = model.log_size();
      for (int i = 0; i < n; i++)
         if (k < 4 && model.log_word(i) == want[k])
         begin
            if (k < 3 || (i + 1 < n && model.log_word(i + 1) == 16'h000D))
               k++;                                  // Desync must follow WR_CMD
         end
      assert (k == 4)
      else
      begin
         $display("Startup stream lacks the sync, GENERAL_5 read or desync words");
         fail_run();
      end
   endtask

   task automatic run_reboot(input design_num_t d, input icap_word_t gen5_exp);
      logic [31:0] boot;
      icap_word_t  expected [16];
      int          start;
      boot     = boot_words(d);
      expected = '{16'hFFFF, 16'hAA99, 16'h5566, 16'h3261, boot[31:16], 16'h3281,
                   boot[15:0], 16'h32E1, gen5_exp, 16'h30A1, 16'h000E, 16'h2000,
                   16'h2000, 16'h2000, 16'h2000, 16'hFFFF};
      design_num  = d;
      start       = model.log_size();
      reconfigure = 1'b1;
      next_cycle();
      reconfigure = 1'b0;
      wait_init(1'b0, 10, "initialized did not drop after reconfigure");
      wait_init(1'b1, 100, "reboot stream did not return to idle");
      check_value(model.log_size() - start, 32'd16, $sformatf("word count, design %0d", d));
      for (int i = 0; i < 16; i++)
         check_value(32'(model.log_word(start + i)), 32'(expected[i]),
                     $sformatf("reboot word %0d, design %0d", i, d));
   endtask

   // ------------------------------------------------------------------------
   // Tests
   // ------------------------------------------------------------------------
   task automatic test_startup();
      logic [31:0] r;
      r          = next_random();
      gen5_value = r[15:0];
      powerup    = 1'b0;
      apply_reset();
      wait_init(1'b1, 200, "initialized never rose after reset");
      check_readback_stream();
   endtask

   task automatic test_soft_dip();
      logic [31:0] r;
      for (int i = 0; i < 3; i++)
      begin
         r          = next_random();
         gen5_value = r[15:0];
         apply_reset();
         wait_init(1'b1, 200, "initialized never rose after reset");
         check_value(32'(sw_out), 32'(gen5_value[3:0]), "sw_out from soft DIP");
         check_value(32'(pwr_out), 32'(gen5_value[7:4]), "pwr_out from soft DIP");
      end
   endtask

   task automatic test_powerup_bypass();
      logic [31:0] r;
      powerup = 1'b1;
      for (int i = 0; i < 8; i++)
      begin
         r     = next_random();
         sw_in = r[3:0];
         next_cycle();
         check_value(32'(sw_out), 32'(sw_in), "sw_out with powerup");
         check_value(32'(pwr_out), 32'(sw_in), "pwr_out with powerup");
      end
      powerup = 1'b0;
   endtask

   task automatic test_reboot_designs();
      design_num_t designs [7] = '{5'd0, 5'd2, 5'd7, 5'd9, 5'd14, 5'd16, 5'd20};
      for (int i = 0; i < 7; i++)
         run_reboot(designs[i], {8'h00, gen5_value[7:4], designs[i][3:0]});
   endtask

   task automatic test_reboot_powerup();
      logic [31:0] r;
      r       = next_random();
      powerup = 1'b1;
      sw_in   = r[3:0];
      run_reboot(5'd5, {8'h00, r[3:0], r[3:0]});
      powerup = 1'b0;
   endtask

   initial
   begin
      #200_000;
      $display("Watchdog expired before the tests finished");
      fail_run();
   end

   initial
   begin
      rst         = 1'b1;
      design_num  = '0;
      reconfigure = 1'b0;
      powerup     = 1'b0;
      sw_in       = '0;
      gen5_value  = '0;
      test_startup();
      test_soft_dip();
      test_powerup_bypass();
      test_reboot_designs();
      test_reboot_powerup();
      if (DUT.u_sequencer.u_assert.failures == 0)
      begin
         $display("=== PASS ===");
         $finish;
      end
      else
      begin
         $display("Port protocol assertions failed");
         fail_run();
      end
   end

endmodule

/* verif/icap_multiboot_assert.sv */
`timescale 1ns/1ps

module icap_multiboot_assert
   import icap_multiboot_pkg::*;
(
   input logic       clk_16M00,
   input logic       rst,
   input icap_cmd_t  icap_cmd,
   input logic       initialized,
   input logic       dip_load
);

   int unsigned failures = 0;

   csib_in_reset: assert property (@(posedge clk_16M00) rst |=> icap_cmd.csib)
   else
   begin
      $error("csib low after a reset cycle");
      failures++;
   end

   // Direction change needs two deselected cycles
   rdwrb_stable: assert property (@(posedge clk_16M00) disable iff (rst)
      $changed(icap_cmd.rdwrb) |-> icap_cmd.csib && $past(icap_cmd.csib))
   else
   begin
      $error("rdwrb changed while csib was low");
      failures++;
   end

   csib_when_idle: assert property (@(posedge clk_16M00) disable iff (rst)
      initialized |-> icap_cmd.csib)
   else
   begin
      $error("csib low while initialized");
      failures++;
   end

   dip_load_pulse: assert property (@(posedge clk_16M00) disable iff (rst)
      dip_load |=> !dip_load)
   else
   begin
      $error("dip_load held longer than one cycle");
      failures++;
   end

endmodule

bind icap_sequencer icap_multiboot_assert u_assert (
   .clk_16M00   (clk_16M00),
   .rst         (rst),
   .icap_cmd    (icap_cmd),
   .initialized (initialized),
   .dip_load    (dip_load)
);

/* verif/icap_model.sv */
`timescale 1ns/1ps

module icap_model
   import icap_multiboot_pkg::*;
#(
   parameter logic [31:0] SEED = 32'h363c_bba4
)
(
   input  logic       clk_16M00,
   input  logic       rst,
   input  icap_cmd_t  icap_cmd,
   input  icap_word_t gen5_value,          // GENERAL_5 contents, logical order
   output icap_rsp_t  icap_rsp
);

   icap_word_t  wr_log [$];               // Written words, un-swapped
   logic [31:0] rng_state = SEED;
   logic [1:0]  busy_left;
   logic        reading;

   function automatic icap_word_t mirror_bytes(input icap_word_t w);
      icap_word_t r;
      for (int i = 0; i < 16; i++)
         r[i] = w[(i & 8) | (7 - (i & 7))];
      return r;
   endfunction

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   function automatic int log_size();
      return wr_log.size();
   endfunction

   function automatic icap_word_t log_word(input int idx);
      return wr_log[idx];
   endfunction

   always @(posedge clk_16M00)
   begin
      if (rst)
      begin
         wr_log.delete();
         reading       <= 1'b0;
         busy_left     <= '0;
         icap_rsp.busy <= 1'b0;
         icap_rsp.dout <= '1;
      end
      else if (!icap_cmd.csib && !icap_cmd.rdwrb)
      begin
         wr_log.push_back(mirror_bytes(icap_cmd.word));
         reading       <= 1'b0;
         icap_rsp.busy <= 1'b0;
      end
      else if (!icap_cmd.csib && icap_cmd.rdwrb)
      begin
         if (!reading)
         begin
            rng_state = xorshift32(rng_state);
            reading       <= 1'b1;
            icap_rsp.busy <= 1'b1;
            busy_left     <= rng_state[1:0];        // Busy for 1 to 4 cycles
         end
         else if (icap_rsp.busy)
         begin
            if (busy_left == 2'd0)
            begin
               icap_rsp.busy <= 1'b0;
               icap_rsp.dout <= mirror_bytes(gen5_value);
            end
            else
               busy_left <= busy_left - 2'd1;
         end
      end
      else
      begin
         reading       <= 1'b0;                   // Deselect ends the read
         icap_rsp.busy <= 1'b0;
      end
   end

endmodule

/* hdl/icap_multiboot_top.sv */
`timescale 1ns/1ps

module icap_multiboot_top
   import icap_multiboot_pkg::*;
#(
   parameter int STARTUP_CYCLES = 15
)
(
   input  logic        clk_16M00,
   input  logic        rst,
   input  design_num_t design_num,
   input  logic        reconfigure,
   input  logic        powerup,
   input  sw_t         sw_in,
   output sw_t         sw_out,
   output sw_t         pwr_out,
   output logic        initialized,
   output icap_cmd_t   icap_cmd,
   input  icap_rsp_t   icap_rsp
);

   icap_word_t gen1_word;
   icap_word_t gen2_word;
   logic       dip_load;
   soft_dip_t  dip_data;
   soft_dip_t  soft_dip;

   icap_sequencer #(
      .STARTUP_CYCLES (STARTUP_CYCLES)
   ) u_sequencer (
      .clk_16M00   (clk_16M00),
      .rst         (rst),
      .reconfigure (reconfigure),
      .powerup     (powerup),
      .sw_in       (sw_in),
      .design_num  (design_num),
      .gen1_word   (gen1_word),
      .gen2_word   (gen2_word),
      .soft_dip    (soft_dip),
      .icap_rsp    (icap_rsp),
      .icap_cmd    (icap_cmd),
      .dip_load    (dip_load),
      .dip_data    (dip_data),
      .initialized (initialized)
   );

   boot_address_map u_address_map (
      .design_num (design_num),
      .gen1_word  (gen1_word),
      .gen2_word  (gen2_word)
   );

   switch_select u_switch_select (
      .clk_16M00 (clk_16M00),
      .rst       (rst),
      .dip_load  (dip_load),
      .dip_data  (dip_data),
      .powerup   (powerup),
      .sw_in     (sw_in),
      .soft_dip  (soft_dip),
      .sw_out    (sw_out),
      .pwr_out   (pwr_out)
   );

endmodule

/* hdl/switch_select.sv */
`timescale 1ns/1ps

module switch_select
   import icap_multiboot_pkg::*;
(
   input  logic      clk_16M00,
   input  logic      rst,
   input  logic      dip_load,
   input  soft_dip_t dip_data,
   input  logic      powerup,
   input  sw_t       sw_in,
   output soft_dip_t soft_dip,
   output sw_t       sw_out,
   output sw_t       pwr_out
);

   // Byte read back from GENERAL_5 at startup
   always_ff @(posedge clk_16M00)
   begin
      if (rst)
         soft_dip <= '0;
      else if (dip_load)
         soft_dip <= dip_data;
   end

   // Powerup bypasses the stored byte entirely
   assign sw_out  = powerup ? sw_in : soft_dip[3:0];
   assign pwr_out = powerup ? sw_in : soft_dip[7:4];

endmodule

/* hdl/icap_sequencer.sv */
`timescale 1ns/1ps

module icap_sequencer
   import icap_multiboot_pkg::*;
#(
   parameter int STARTUP_CYCLES = 15
)
(
   input  logic        clk_16M00,
   input  logic        rst,
   input  logic        reconfigure,
   input  logic        powerup,
   input  sw_t         sw_in,
   input  design_num_t design_num,
   input  icap_word_t  gen1_word,
   input  icap_word_t  gen2_word,
   input  soft_dip_t   soft_dip,
   input  icap_rsp_t   icap_rsp,
   output icap_cmd_t   icap_cmd,
   output logic        dip_load,
   output soft_dip_t   dip_data,
   output logic        initialized
);

   // Wide enough for the startup delay and the four-NOOP runs
   localparam int CNT_W = $clog2(STARTUP_CYCLES + 4);
   localparam logic [CNT_W-1:0] STARTUP_LAST = CNT_W'(STARTUP_CYCLES - 1);

   seq_state_t       state;
   seq_state_t       state_next;
   logic [CNT_W-1:0] dwell_cnt;                 // Cycles spent in current state
   icap_word_t       word_next;
   logic             csib_next;
   logic             rdwrb_next;
   icap_word_t       gen5_word;
   icap_word_t       dout_logical;

   assign gen5_word = {8'h00,
                       powerup ? sw_in : soft_dip[7:4],
                       powerup ? sw_in : design_num[3:0]};

   assign dout_logical = icap_bit_swap(icap_rsp.dout);
   assign dip_data     = dout_logical[7:0];
   assign dip_load     = (state == RD_LATCH) && !icap_rsp.busy;

   // -------------------------------------------------------------------------
   // Next state
   // -------------------------------------------------------------------------
   always_comb
   begin
      state_next = state;
      case (state)
         ST_STARTUP:
            if (dwell_cnt == STARTUP_LAST)
               state_next = RD_NULL;
         RD_NULL:       state_next = RD_SYNC_H;
         RD_SYNC_H:     state_next = RD_SYNC_L;
         RD_SYNC_L:     state_next = RD_NOOP_PRE;
         RD_NOOP_PRE:
            if (dwell_cnt == CNT_W'(1))
               state_next = RD_GEN5;
         RD_GEN5:       state_next = RD_NOOP_POST;
         RD_NOOP_POST:
            if (dwell_cnt == CNT_W'(3))
               state_next = RD_ABORT_1;
         RD_ABORT_1:    state_next = RD_ABORT_2;
         RD_ABORT_2:    state_next = RD_READ;
         RD_READ:       state_next = RD_WAIT;
         RD_WAIT:       state_next = RD_LATCH;  // Let busy assert
         RD_LATCH:
            if (!icap_rsp.busy)
               state_next = RD_ABORT_3;
         RD_ABORT_3:    state_next = RD_DESYNC_CMD;
         RD_DESYNC_CMD: state_next = RD_DESYNC;
         RD_DESYNC:     state_next = RD_NOOP_END;
         RD_NOOP_END:
            if (dwell_cnt == CNT_W'(1))
               state_next = IDLE;
         IDLE:
            if (reconfigure)
               state_next = RB_NULL;
         RB_NULL:       state_next = RB_SYNC_H;
         RB_SYNC_H:     state_next = RB_SYNC_L;
         RB_SYNC_L:     state_next = RB_GEN1_CMD;
         RB_GEN1_CMD:   state_next = RB_GEN1;
         RB_GEN1:       state_next = RB_GEN2_CMD;
         RB_GEN2_CMD:   state_next = RB_GEN2;
         RB_GEN2:       state_next = RB_GEN5_CMD;
         RB_GEN5_CMD:   state_next = RB_GEN5;
         RB_GEN5:       state_next = RB_REBOOT_CMD;
         RB_REBOOT_CMD: state_next = RB_REBOOT;
         RB_REBOOT:     state_next = RB_NOOP;
         RB_NOOP:
            if (dwell_cnt == CNT_W'(3))
               state_next = RB_NULL_END;
         RB_NULL_END:   state_next = IDLE;
         default:       state_next = IDLE;
      endcase
   end

   // -------------------------------------------------------------------------
   // Port word and strobes chosen per state
   // -------------------------------------------------------------------------
   always_comb
   begin
      case (state)
         RD_SYNC_H, RB_SYNC_H:          word_next = SYNC_H_WORD;
         RD_SYNC_L, RB_SYNC_L:          word_next = SYNC_L_WORD;
         RD_NOOP_PRE, RD_NOOP_POST,
         RD_NOOP_END, RB_NOOP:          word_next = NOOP_WORD;
         RD_GEN5:                       word_next = RD_GEN5_WORD;
         RD_DESYNC_CMD, RB_REBOOT_CMD:  word_next = WR_CMD_WORD;
         RD_DESYNC:                     word_next = DESYNC_WORD;
         RB_GEN1_CMD:                   word_next = WR_GEN1_WORD;
         RB_GEN1:                       word_next = gen1_word;
         RB_GEN2_CMD:                   word_next = WR_GEN2_WORD;
         RB_GEN2:                       word_next = gen2_word;
         RB_GEN5_CMD:                   word_next = WR_GEN5_WORD;
         RB_GEN5:                       word_next = gen5_word;
         RB_REBOOT:                     word_next = REBOOT_WORD;
         default:                       word_next = NULL_WORD;
      endcase
   end

   // Deselect around every rdwrb change so the read is not aborted
   assign csib_next  = (state inside {ST_STARTUP, RD_ABORT_1, RD_ABORT_2, RD_ABORT_3, IDLE})
                       || dip_load;
   assign rdwrb_next = state inside {RD_ABORT_2, RD_READ, RD_WAIT, RD_LATCH};

   // -------------------------------------------------------------------------
   // Registers
   // -------------------------------------------------------------------------
   always_ff @(posedge clk_16M00)
   begin
      if (rst)
      begin
         state     <= ST_STARTUP;
         dwell_cnt <= '0;
      end
      else
      begin
         state <= state_next;
         if (state_next != state)
            dwell_cnt <= '0;
         else
            dwell_cnt <= dwell_cnt + 1'b1;
      end
   end

   // initialized lines up with icap_cmd, one clock behind the state
   always_ff @(posedge clk_16M00)
   begin
      if (rst)
      begin
         icap_cmd.csib  <= 1'b1;
         icap_cmd.rdwrb <= 1'b0;
         initialized    <= 1'b0;
      end
      else
      begin
         icap_cmd.csib  <= csib_next;
         icap_cmd.rdwrb <= rdwrb_next;
         initialized    <= (state == IDLE);
      end
      icap_cmd.word <= icap_bit_swap(word_next);
   end

endmodule

/* hdl/boot_address_map.sv */
`timescale 1ns/1ps

module boot_address_map
   import icap_multiboot_pkg::*;
(
   input  design_num_t design_num,
   output icap_word_t  gen1_word,
   output icap_word_t  gen2_word
);

   always_comb
   begin
      case (design_num)
         5'd16:
         begin
            gen1_word = 16'h0000;          // Golden image
            gen2_word = 16'h0300;
         end
         5'd0:
         begin
            gen1_word = 16'h4000;
            gen2_word = 16'h0305;
         end
         5'd1:
         begin
            gen1_word = 16'h8000;
            gen2_word = 16'h030A;
         end
         5'd2:
         begin
            gen1_word = 16'hC000;
            gen2_word = 16'h030F;
         end
         5'd3:
         begin
            gen1_word = 16'h0000;
            gen2_word = 16'h0315;
         end
         5'd4:
         begin
            gen1_word = 16'h4000;
            gen2_word = 16'h031A;
         end
         5'd7:
         begin
            gen1_word = 16'h0000;
            gen2_word = 16'h032A;
         end
         5'd8, 5'd9, 5'd10, 5'd11:
         begin
            gen1_word = 16'h8000;          // Shared slot
            gen2_word = 16'h031F;
         end
         5'd12, 5'd13, 5'd14, 5'd15:
         begin
            gen1_word = 16'hC000;
            gen2_word = 16'h0324;
         end
         default:
         begin
            gen1_word = 16'h4000;          // Null co-processor image
            gen2_word = 16'h032F;
         end
      endcase
   end

endmodule

/* hdl/icap_multiboot_pkg.sv */
package icap_multiboot_pkg;

   // -------------------------------------------------------------------------
   // Basic types
   // -------------------------------------------------------------------------
   typedef logic [15:0] icap_word_t;    // Configuration word, logical order
   typedef logic [4:0]  design_num_t;
   typedef logic [7:0]  soft_dip_t;     // Power nibble high, switches low
   typedef logic [3:0]  sw_t;

   typedef struct packed {
      icap_word_t word;                 // Already bit-swapped
      logic       csib;                 // Active low select
      logic       rdwrb;                // 1 = read, 0 = write
   } icap_cmd_t;

   typedef struct packed {
      icap_word_t dout;                 // Swapped, as delivered by the port
      logic       busy;
   } icap_rsp_t;

   // -------------------------------------------------------------------------
   // Configuration words
   // -------------------------------------------------------------------------
   localparam icap_word_t NULL_WORD    = 16'hFFFF;
   localparam icap_word_t SYNC_H_WORD  = 16'hAA99;
   localparam icap_word_t SYNC_L_WORD  = 16'h5566;
   localparam icap_word_t NOOP_WORD    = 16'h2000;
   localparam icap_word_t RD_GEN5_WORD = 16'h2AE1;  // Type 1 read, GENERAL_5
   localparam icap_word_t WR_GEN1_WORD = 16'h3261;
   localparam icap_word_t WR_GEN2_WORD = 16'h3281;
   localparam icap_word_t WR_GEN5_WORD = 16'h32E1;
   localparam icap_word_t WR_CMD_WORD  = 16'h30A1;  // Write to CMD register
   localparam icap_word_t DESYNC_WORD  = 16'h000D;
   localparam icap_word_t REBOOT_WORD  = 16'h000E;

   // -------------------------------------------------------------------------
   // Sequencer states
   // -------------------------------------------------------------------------
   typedef enum logic [4:0] {
      ST_STARTUP,
      RD_NULL,
      RD_SYNC_H,
      RD_SYNC_L,
      RD_NOOP_PRE,                      // Two NOOPs
      RD_GEN5,
      RD_NOOP_POST,                     // Four NOOPs
      RD_ABORT_1,
      RD_ABORT_2,
      RD_READ,
      RD_WAIT,
      RD_LATCH,
      RD_ABORT_3,
      RD_DESYNC_CMD,
      RD_DESYNC,
      RD_NOOP_END,                      // Two NOOPs
      IDLE,
      RB_NULL,
      RB_SYNC_H,
      RB_SYNC_L,
      RB_GEN1_CMD,
      RB_GEN1,
      RB_GEN2_CMD,
      RB_GEN2,
      RB_GEN5_CMD,
      RB_GEN5,
      RB_REBOOT_CMD,
      RB_REBOOT,
      RB_NOOP,                          // Four NOOPs
      RB_NULL_END
   } seq_state_t;

   // Port shifts D0 first, so each byte goes out mirrored
   function automatic icap_word_t icap_bit_swap(input icap_word_t w);
      icap_word_t r;
      for (int i = 0; i < 8; i++)
      begin
         r[i]     = w[7 - i];
         r[8 + i] = w[15 - i];
      end
      return r;
   endfunction

endpackage
